//--- verilog/VideoTxPkg.sv
// Video transmit package with display timing, register map and bus/pixel/video types

package VideoTxPkg;

	// --------------------------------------------------
	// Display timing, kept small for short frames
	// --------------------------------------------------
	localparam int VHA = 16;
	localparam int VHS = 3;
	localparam int VHB = 4;
	localparam int VHF = 2;
	localparam int VHT = VHS + VHB + VHA + VHF;

	localparam int VVA = 8;
	localparam int VVS = 2;
	localparam int VVB = 2;
	localparam int VVF = 1;
	localparam int VVT = VVS + VVB + VVA + VVF;

	// Coordinate widths, also wide enough for the full line and frame counts
	localparam int XW = 5;
	localparam int YW = 4;

	localparam int FifoDepth = 16;

	// --------------------------------------------------
	// Register map
	// --------------------------------------------------
	localparam logic [3:0] AdrCtrl     = 4'd0;
	localparam logic [3:0] AdrBg       = 4'd1;
	localparam logic [3:0] AdrR1Color  = 4'd2;
	localparam logic [3:0] AdrR1Left   = 4'd3;
	localparam logic [3:0] AdrR1Right  = 4'd4;
	localparam logic [3:0] AdrR1Top    = 4'd5;
	localparam logic [3:0] AdrR1Under  = 4'd6;
	localparam logic [3:0] AdrR2Color  = 4'd7;
	localparam logic [3:0] AdrR2Left   = 4'd8;
	localparam logic [3:0] AdrR2Right  = 4'd9;
	localparam logic [3:0] AdrR2Top    = 4'd10;
	localparam logic [3:0] AdrR2Under  = 4'd11;
	localparam logic [3:0] AdrFrameCnt = 4'd12;

	// --------------------------------------------------
	// Types
	// --------------------------------------------------
	typedef struct packed {
		logic [3:0]  adr;
		logic        wr;
		logic [15:0] wdata;
	} csrReqT;

	typedef struct packed {
		logic [15:0] rdata;
	} csrRspT;

	typedef struct packed {
		logic [15:0]   color;
		logic [XW-1:0] left;
		logic [XW-1:0] right;
		logic [YW-1:0] top;
		logic [YW-1:0] under;
	} rectT;

	// rect[0] is rectangle 1, rect[1] is rectangle 2
	typedef struct packed {
		logic        enable;
		logic [15:0] bg;
		rectT [1:0]  rect;
	} videoCfgT;

	typedef struct packed {
		logic hs;
		logic vs;
		logic de;
		logic fe;
	} syncT;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		syncT       sync;
	} videoOutT;

	// RGB565
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} pixelT;

endpackage

//--- verilog/VideoTxCsr.sv
// Video transmit register block with four-phase req/ack slave and frame counter

`timescale 1ns/100ps

module VideoTxCsr (
	input  logic                 iVCLK,
	input  logic                 iVRST,
	input  logic                 req,
	input  VideoTxPkg::csrReqT   reqData,
	output logic                 ack,
	output VideoTxPkg::csrRspT   rspData,
	input  logic                 frameEnd,
	output VideoTxPkg::videoCfgT cfg
);
	import VideoTxPkg::*;

	logic        accept;
	logic [15:0] frameCnt;
	logic [15:0] rdMux;

	// New access seen while idle
	assign accept = req && !ack;

	// --------------------------------------------------
	// Handshake
	// --------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			ack <= 1'b0;
			rspData <= '0;
		end
		else if (accept)
		begin
			ack <= 1'b1;
			rspData.rdata <= rdMux;
		end
		else if (!req)
		begin
			ack <= 1'b0;
		end
	end

	// --------------------------------------------------
	// Settings registers
	// --------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			cfg <= '0;
		end
		else if (accept && reqData.wr)
		begin
			case (reqData.adr)
				AdrCtrl:    cfg.enable        <= reqData.wdata[0];
				AdrBg:      cfg.bg            <= reqData.wdata;
				AdrR1Color: cfg.rect[0].color <= reqData.wdata;
				AdrR1Left:  cfg.rect[0].left  <= reqData.wdata[XW-1:0];
				AdrR1Right: cfg.rect[0].right <= reqData.wdata[XW-1:0];
				AdrR1Top:   cfg.rect[0].top   <= reqData.wdata[YW-1:0];
				AdrR1Under: cfg.rect[0].under <= reqData.wdata[YW-1:0];
				AdrR2Color: cfg.rect[1].color <= reqData.wdata;
				AdrR2Left:  cfg.rect[1].left  <= reqData.wdata[XW-1:0];
				AdrR2Right: cfg.rect[1].right <= reqData.wdata[XW-1:0];
				AdrR2Top:   cfg.rect[1].top   <= reqData.wdata[YW-1:0];
				AdrR2Under: cfg.rect[1].under <= reqData.wdata[YW-1:0];
				default:    ;
			endcase
		end
	end

	// Frame counter, wraps
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
			frameCnt <= '0;
		else if (frameEnd)
			frameCnt <= frameCnt + 16'd1;
	end

	// Readback, unused bits read zero
	always_comb
	begin
		case (reqData.adr)
			AdrCtrl:     rdMux = 16'(cfg.enable);
			AdrBg:       rdMux = cfg.bg;
			AdrR1Color:  rdMux = cfg.rect[0].color;
			AdrR1Left:   rdMux = 16'(cfg.rect[0].left);
			AdrR1Right:  rdMux = 16'(cfg.rect[0].right);
			AdrR1Top:    rdMux = 16'(cfg.rect[0].top);
			AdrR1Under:  rdMux = 16'(cfg.rect[0].under);
			AdrR2Color:  rdMux = cfg.rect[1].color;
			AdrR2Left:   rdMux = 16'(cfg.rect[1].left);
			AdrR2Right:  rdMux = 16'(cfg.rect[1].right);
			AdrR2Top:    rdMux = 16'(cfg.rect[1].top);
			AdrR2Under:  rdMux = 16'(cfg.rect[1].under);
			AdrFrameCnt: rdMux = frameCnt;
			default:     rdMux = '0;
		endcase
	end

	// --------------------------------------------------
	// Bus protocol checks
	// --------------------------------------------------
	ackNeedsReq: assert property (@(posedge iVCLK) disable iff (iVRST)
		$rose(ack) |-> $past(req));

	reqDataStable: assert property (@(posedge iVCLK) disable iff (iVRST)
		req && $past(req) |-> $stable(reqData));

endmodule

//--- verilog/VideoSyncGen.sv
// Video sync generator producing HS, VS, DE and FE from the fixed display timing

`timescale 1ns/100ps

module VideoSyncGen (
	input  logic             iVCLK,
	input  logic             iVRST,
	input  logic             enable,
	output VideoTxPkg::syncT sync,
	output logic             frameEnd
);
	import VideoTxPkg::*;

	logic [3:0]    startCnt;
	logic          run;
	logic          active;
	logic [XW-1:0] hCnt;
	logic [YW-1:0] vCnt;
	logic          lineEnd;
	logic          lastLine;
	logic          hActive;
	logic          vActive;

	// --------------------------------------------------
	// Start delay after enable, lets the FIFO fill
	// --------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST || !enable)
		begin
			startCnt <= '0;
			run <= 1'b0;
		end
		else if (!run)
		begin
			startCnt <= startCnt + 4'd1;
			run <= (startCnt == 4'd15);
		end
	end

	assign active = run && enable;

	// --------------------------------------------------
	// Line and frame counters
	// --------------------------------------------------
	assign lineEnd  = (hCnt == XW'(VHT - 1));
	assign lastLine = (vCnt == YW'(VVT - 1));

	always_ff @(posedge iVCLK)
	begin
		if (iVRST || !active)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else if (lineEnd)
		begin
			hCnt <= '0;
			vCnt <= lastLine ? '0 : vCnt + 1'b1;
		end
		else
		begin
			hCnt <= hCnt + 1'b1;
		end
	end

	// Sync first, then back porch, active, front porch
	assign hActive = (hCnt >= XW'(VHS + VHB)) && (hCnt < XW'(VHS + VHB + VHA));
	assign vActive = (vCnt >= YW'(VVS + VVB)) && (vCnt < YW'(VVS + VVB + VVA));

	assign sync.hs  = active && (hCnt < XW'(VHS));
	assign sync.vs  = active && (vCnt < YW'(VVS));
	assign sync.de  = active && hActive && vActive;
	assign sync.fe  = active && lineEnd && lastLine;
	assign frameEnd = sync.fe;

	deOutsideSync: assert property (@(posedge iVCLK) disable iff (iVRST)
		sync.de |-> !sync.hs && !sync.vs);

endmodule

//--- verilog/DotSquareGen.sv
// Rectangle pixel generator that scans the active area and fills the line FIFO

`timescale 1ns/100ps

module DotSquareGen (
	input  logic                 iVCLK,
	input  logic                 iVRST,
	input  VideoTxPkg::videoCfgT cfg,
	input  logic                 frameEnd,
	input  logic                 full,
	output logic                 push,
	output VideoTxPkg::pixelT    pixel,
	output logic                 flush
);
	import VideoTxPkg::*;

	logic [15:0]   bgS;
	rectT [1:0]    rectS;
	logic          enD;
	logic          hold;
	logic [XW-1:0] x;
	logic [YW-1:0] y;
	logic          rowEnd;
	logic          lastPixel;
	logic [1:0]    hit;

	assign flush = !cfg.enable;

	// Nothing goes out on the enable edge, the shadow copy loads there
	assign push = cfg.enable && enD && !hold && !full;

	assign rowEnd    = (x == XW'(VHA - 1));
	assign lastPixel = rowEnd && (y == YW'(VVA - 1));

	// --------------------------------------------------
	// Shadow copy of the settings, one per frame
	// --------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if ((cfg.enable && !enD) || frameEnd)
		begin
			bgS <= cfg.bg;
			rectS <= cfg.rect;
		end
	end

	// --------------------------------------------------
	// Scan position
	// --------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST || !cfg.enable)
		begin
			enD <= 1'b0;
			hold <= 1'b0;
			x <= '0;
			y <= '0;
		end
		else
		begin
			enD <= 1'b1;
			// Next frame waits for its settings
			if (frameEnd)
				hold <= 1'b0;
			if (push)
			begin
				if (rowEnd)
				begin
					x <= '0;
					y <= lastPixel ? '0 : y + 1'b1;
					if (lastPixel)
						hold <= 1'b1;
				end
				else
				begin
					x <= x + 1'b1;
				end
			end
		end
	end

	// Hit test, edges inclusive, rectangle 2 on top
	always_comb
	begin
		for (int i = 0; i < 2; i++)
		begin
			hit[i] = (x >= rectS[i].left) && (x <= rectS[i].right) &&
				(y >= rectS[i].top) && (y <= rectS[i].under);
		end
		if (hit[1])
			pixel = pixelT'(rectS[1].color);
		else if (hit[0])
			pixel = pixelT'(rectS[0].color);
		else
			pixel = pixelT'(bgS);
	end

endmodule

//--- verilog/PixelFifo.sv
// Single-clock pixel FIFO with registered read data and full/empty flags

`timescale 1ns/100ps

module PixelFifo #(
	parameter int Depth = VideoTxPkg::FifoDepth
) (
	input  logic              iVCLK,
	input  logic              iVRST,
	input  logic              flush,
	input  logic              push,
	input  VideoTxPkg::pixelT wdata,
	input  logic              pop,
	output VideoTxPkg::pixelT rdata,
	output logic              full,
	output logic              empty
);
	import VideoTxPkg::*;

	localparam int AW = $clog2(Depth);
	localparam int CW = $clog2(Depth + 1);

	pixelT         mem [Depth];
	logic [AW-1:0] wrPtr;
	logic [AW-1:0] rdPtr;
	logic [CW-1:0] count;
	logic          doPush;
	logic          doPop;

	assign full   = (count == CW'(Depth));
	assign empty  = (count == '0);
	assign doPush = push && !full;
	assign doPop  = pop && !empty;

	// Pointers and fill count
	always_ff @(posedge iVCLK)
	begin
		if (iVRST || flush)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= (wrPtr == AW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == AW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// Storage, data out one cycle after pop
	always_ff @(posedge iVCLK)
	begin
		if (doPush)
			mem[wrPtr] <= wdata;
		if (doPop)
			rdata <= mem[rdPtr];
	end

	noUnderflow: assert property (@(posedge iVCLK) disable iff (iVRST) !(pop && empty));

	noOverflow: assert property (@(posedge iVCLK) disable iff (iVRST) !(push && full));

endmodule

//--- verilog/VideoTxBlock.sv
// Video transmit top level joining registers, sync, pixel generator and line FIFO

`timescale 1ns/100ps

module VideoTxBlock (
	input  logic                 iVCLK,
	input  logic                 iVRST,
	input  logic                 req,
	input  VideoTxPkg::csrReqT   reqData,
	output logic                 ack,
	output VideoTxPkg::csrRspT   rspData,
	output VideoTxPkg::videoOutT video
);
	import VideoTxPkg::*;

	videoCfgT cfg;
	syncT     sync;
	syncT     syncD;
	logic     frameEnd;
	logic     push;
	logic     flush;
	logic     full;
	pixelT    genPixel;
	pixelT    fifoPixel;

	// --------------------------------------------------
	// Blocks
	// --------------------------------------------------
	VideoTxCsr VideoTxCsr_i (
		.iVCLK    (iVCLK),
		.iVRST    (iVRST),
		.req      (req),
		.reqData  (reqData),
		.ack      (ack),
		.rspData  (rspData),
		.frameEnd (frameEnd),
		.cfg      (cfg)
	);

	VideoSyncGen VideoSyncGen_i (
		.iVCLK    (iVCLK),
		.iVRST    (iVRST),
		.enable   (cfg.enable),
		.sync     (sync),
		.frameEnd (frameEnd)
	);

	DotSquareGen DotSquareGen_i (
		.iVCLK    (iVCLK),
		.iVRST    (iVRST),
		.cfg      (cfg),
		.frameEnd (frameEnd),
		.full     (full),
		.push     (push),
		.pixel    (genPixel),
		.flush    (flush)
	);

	// DE pops the line FIFO directly
	PixelFifo PixelFifo_i (
		.iVCLK (iVCLK),
		.iVRST (iVRST),
		.flush (flush),
		.push  (push),
		.wdata (genPixel),
		.pop   (sync.de),
		.rdata (fifoPixel),
		.full  (full),
		.empty ()
	);

	// --------------------------------------------------
	// Sync alignment and output register
	// --------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			syncD <= '0;
			video <= '0;
		end
		else
		begin
			syncD <= sync;
			video.sync <= syncD;
			// RGB565 widened with zero LSBs, black outside DE
			if (syncD.de)
			begin
				video.r <= {fifoPixel.r, 3'b000};
				video.g <= {fifoPixel.g, 2'b00};
				video.b <= {fifoPixel.b, 3'b000};
			end
			else
			begin
				video.r <= '0;
				video.g <= '0;
				video.b <= '0;
			end
		end
	end

endmodule

//--- sim/VideoTxChecker.sv
// Video output checker comparing pixels with the rectangle rules and measuring sync timing

`timescale 1ns/100ps

module VideoTxChecker (
	input  logic                 iVCLK,
	input  logic                 iVRST,
	input  VideoTxPkg::videoOutT video
);
	import VideoTxPkg::*;

	// Settings mirror and test name, kept up to date by the testbench
	videoCfgT liveCfg = '0;
	string    testName = "none";

	videoCfgT    frameCfg;
	logic [23:0] expRgb;
	logic        feSeen;
	int          col;
	int          row;
	int          hsRun;
	int          vsRun;
	int          hsCount;
	int          vsCount;
	int          frameCyc;
	int          feCount = 0;
	int          videoErrors = 0;
	int          timingErrors = 0;

	// Expected 8-bit channels for one pixel, later rectangle wins, edges inclusive
	function automatic logic [23:0] colorOf(input int x, input int y, input videoCfgT cfg);
		logic [15:0] c;
		c = cfg.bg;
		for (int i = 0; i < 2; i++)
		begin
			if (x >= cfg.rect[i].left && x <= cfg.rect[i].right &&
				y >= cfg.rect[i].top && y <= cfg.rect[i].under)
				c = cfg.rect[i].color;
		end
		return {c[15:11], 3'b000, c[10:5], 2'b00, c[4:0], 3'b000};
	endfunction

	task automatic checkCount(input string what, input int expected, input int actual);
		if (actual != expected)
		begin
			timingErrors++;
			$display("FAIL %s: %s expected %0d actual %0d", testName, what, expected, actual);
		end
	endtask

	// --------------------------------------------------
	// Frame tracking and comparison
	// --------------------------------------------------
	always @(posedge iVCLK)
	begin
		if (video.sync.fe)
			feCount <= feCount + 1;
		// Settings for a frame are the ones seen at the previous frame end
		if (!liveCfg.enable || video.sync.fe)
			frameCfg <= liveCfg;
		if (iVRST || !liveCfg.enable)
		begin
			col <= 0;
			row <= 0;
			hsRun <= 0;
			vsRun <= 0;
			hsCount <= 0;
			vsCount <= 0;
			frameCyc <= 0;
			feSeen <= 1'b0;
		end
		else
		begin
			frameCyc <= frameCyc + 1;
			if (video.sync.de)
			begin
				expRgb = colorOf(col, row, frameCfg);
				if ({video.r, video.g, video.b} !== expRgb)
				begin
					videoErrors++;
					$display("FAIL %s: pixel (%0d,%0d) expected %h actual %h", testName,
						col, row, expRgb, {video.r, video.g, video.b});
				end
				col <= col + 1;
			end
			else if (col != 0)
			begin
				checkCount("de cycles per line", VHA, col);
				col <= 0;
				row <= row + 1;
			end
			if (video.sync.hs)
				hsRun <= hsRun + 1;
			else if (hsRun != 0)
			begin
				checkCount("hs width", VHS, hsRun);
				hsRun <= 0;
				hsCount <= hsCount + 1;
			end
			if (video.sync.vs)
				vsRun <= vsRun + 1;
			else if (vsRun != 0)
			begin
				checkCount("vs width in cycles", VVS * VHT, vsRun);
				vsRun <= 0;
				vsCount <= vsCount + 1;
			end
			if (video.sync.fe)
			begin
				checkCount("de lines per frame", VVA, row);
				checkCount("hs pulses per frame", VVT, hsCount);
				checkCount("vs pulses per frame", 1, vsCount);
				if (feSeen)
					checkCount("frame length", VHT * VVT, frameCyc + 1);
				feSeen <= 1'b1;
				frameCyc <= 0;
				row <= 0;
				hsCount <= 0;
				vsCount <= 0;
			end
		end
	end

endmodule

//--- sim/VideoTxTb.sv
// Video transmit testbench driving the register bus through the display test sequence

`timescale 1ns/100ps

module VideoTxTb;
	import VideoTxPkg::*;

	localparam int ClkPeriod = 20;
	localparam int InDelay = 2;
	localparam int BusLimit = 20;
	// Ten frames of video plus room for the bus accesses
	localparam int WatchdogCycles = 10 * VHT * VVT + 2000;

	logic        iVCLK;
	logic        iVRST;
	logic        req;
	csrReqT      reqData;
	logic        ack;
	csrRspT      rspData;
	videoOutT    video;
	logic [15:0] regExp [16];
	integer      seed;
	int          regErrors;
	int          busErrors;
	int          levelErrors;
	int          total;
	string       testName;

	VideoTxBlock VideoTxBlock_i (
		.iVCLK   (iVCLK),
		.iVRST   (iVRST),
		.req     (req),
		.reqData (reqData),
		.ack     (ack),
		.rspData (rspData),
		.video   (video)
	);

	VideoTxChecker VideoTxChecker_i (
		.iVCLK (iVCLK),
		.iVRST (iVRST),
		.video (video)
	);

	always #(ClkPeriod / 2) iVCLK = ~iVCLK;

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic nextCycle();
		@(posedge iVCLK);
		#InDelay;
	endtask

	task automatic setTest(input string name);
		testName = name;
		VideoTxChecker_i.testName = name;
	endtask

	// Writable bits per register
	function automatic logic [15:0] fieldMask(input logic [3:0] adr);
		case (adr)
			AdrCtrl:                                      return 16'h0001;
			AdrBg, AdrR1Color, AdrR2Color:                return 16'hFFFF;
			AdrR1Left, AdrR1Right, AdrR2Left, AdrR2Right: return 16'((1 << XW) - 1);
			AdrR1Top, AdrR1Under, AdrR2Top, AdrR2Under:   return 16'((1 << YW) - 1);
			default:                                      return 16'h0000;
		endcase
	endfunction

	task automatic updateMirror(input logic [3:0] adr, input logic [15:0] data);
		videoCfgT c;
		regExp[adr] = data & fieldMask(adr);
		c.enable = regExp[AdrCtrl][0];
		c.bg = regExp[AdrBg];
		// Rectangle registers come in groups of five
		for (int i = 0; i < 2; i++)
		begin
			c.rect[i].color = regExp[AdrR1Color + 5 * i];
			c.rect[i].left = regExp[AdrR1Left + 5 * i][XW-1:0];
			c.rect[i].right = regExp[AdrR1Right + 5 * i][XW-1:0];
			c.rect[i].top = regExp[AdrR1Top + 5 * i][YW-1:0];
			c.rect[i].under = regExp[AdrR1Under + 5 * i][YW-1:0];
		end
		VideoTxChecker_i.liveCfg = c;
	endtask

	// One four-phase access, req up, wait ack, req down, wait ack low
	task automatic busAccess(input logic [3:0] adr, input logic wr, input logic [15:0] data,
		output logic [15:0] rdata);
		int waitCnt;
		req = 1'b1;
		reqData.adr = adr;
		reqData.wr = wr;
		reqData.wdata = data;
		waitCnt = 0;
		do
		begin
			nextCycle();
			waitCnt++;
		end
		while (!ack && waitCnt < BusLimit);
		if (!ack)
		begin
			busErrors++;
			$display("Bus access to address %0d was never acknowledged", adr);
		end
		rdata = rspData.rdata;
		if (wr)
			updateMirror(adr, data);
		req = 1'b0;
		waitCnt = 0;
		do
		begin
			nextCycle();
			waitCnt++;
		end
		while (ack && waitCnt < BusLimit);
		if (ack)
		begin
			busErrors++;
			$display("Bus ack to address %0d stayed high after req dropped", adr);
		end
	endtask

	task automatic csrWrite(input logic [3:0] adr, input logic [15:0] data);
		logic [15:0] unused;
		busAccess(adr, 1'b1, data, unused);
	endtask

	task automatic checkRead(input logic [3:0] adr, input logic [15:0] expected);
		logic [15:0] actual;
		busAccess(adr, 1'b0, 16'h0000, actual);
		if (actual !== expected)
		begin
			regErrors++;
			$display("FAIL %s: register %0d expected %h actual %h", testName, adr,
				expected, actual);
		end
	endtask

	// Idle video is black with all sync lines low
	task automatic checkQuiet();
		if (video !== '0 || ack !== 1'b0)
		begin
			levelErrors++;
			$display("FAIL %s: video/ack expected 0000000/0 actual %h/%b", testName,
				video, ack);
		end
	endtask

	task automatic waitFe(input int frames);
		repeat (frames)
		begin
			do
				nextCycle();
			while (!video.sync.fe);
		end
	endtask

	task automatic waitDe();
		do
			nextCycle();
		while (!video.sync.de);
	endtask

	task automatic randomSettings();
		logic [31:0] rnd;
		for (int a = 1; a <= 11; a++)
		begin
			rnd = $random(seed);
			// Edges kept near the screen so most rectangles are visible
			if (fieldMask(4'(a)) == 16'hFFFF)
				csrWrite(4'(a), rnd[15:0]);
			else
				csrWrite(4'(a), {12'h000, rnd[3:0]});
		end
	endtask

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial
	begin
		iVCLK = 1'b0;
		iVRST = 1'b1;
		req = 1'b0;
		reqData = '0;
		seed = 32'hda65674e;
		regErrors = 0;
		busErrors = 0;
		levelErrors = 0;
		foreach (regExp[i])
			regExp[i] = '0;
		setTest("resetState");
		repeat (16) @(posedge iVCLK);
		#InDelay;
		iVRST = 1'b0;
		repeat (20)
		begin
			checkQuiet();
			nextCycle();
		end
		for (int a = 0; a <= 12; a++)
			checkRead(4'(a), 16'h0000);

		setTest("regReadback");
		csrWrite(AdrCtrl, 16'hFFFE);
		csrWrite(AdrFrameCnt, 16'hFFFF);
		for (int a = 1; a <= 11; a++)
			csrWrite(4'(a), 16'($random(seed)));
		for (int a = 0; a <= 12; a++)
			checkRead(4'(a), regExp[a]);

		// Overlapping rectangles, rectangle 2 on top
		setTest("fixedRects");
		csrWrite(AdrBg, 16'h18E3);
		csrWrite(AdrR1Color, 16'hF800);
		csrWrite(AdrR1Left, 16'd2);
		csrWrite(AdrR1Right, 16'd9);
		csrWrite(AdrR1Top, 16'd1);
		csrWrite(AdrR1Under, 16'd5);
		csrWrite(AdrR2Color, 16'h07FF);
		csrWrite(AdrR2Left, 16'd6);
		csrWrite(AdrR2Right, 16'd13);
		csrWrite(AdrR2Top, 16'd3);
		csrWrite(AdrR2Under, 16'd6);
		csrWrite(AdrCtrl, 16'h0001);
		waitFe(2);

		// Written mid-frame, so the empty rectangle shows one frame later
		setTest("emptyRect");
		waitDe();
		csrWrite(AdrR2Left, 16'd12);
		csrWrite(AdrR2Right, 16'd4);
		waitFe(2);

		setTest("randomFrames");
		repeat (3)
		begin
			waitDe();
			randomSettings();
			waitFe(1);
		end
		waitFe(1);

		setTest("frameCounter");
		// The checker tallies an fe pulse on the edge after it shows
		nextCycle();
		checkRead(AdrFrameCnt, 16'(VideoTxChecker_i.feCount));
		csrWrite(AdrCtrl, 16'h0000);
		repeat (4) nextCycle();
		repeat (2 * VHT)
		begin
			checkQuiet();
			nextCycle();
		end
		checkRead(AdrFrameCnt, 16'(VideoTxChecker_i.feCount));

		total = regErrors + busErrors + levelErrors + VideoTxChecker_i.videoErrors +
			VideoTxChecker_i.timingErrors;
		$display("Errors: register %0d, bus %0d, level %0d, pixel %0d, timing %0d",
			regErrors, busErrors, levelErrors, VideoTxChecker_i.videoErrors,
			VideoTxChecker_i.timingErrors);
		if (total == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WatchdogCycles * ClkPeriod);
		$display("Watchdog: the test sequence did not finish within %0d cycles", WatchdogCycles);
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- compile.f
verilog/VideoTxPkg.sv
verilog/VideoTxCsr.sv
verilog/VideoSyncGen.sv
verilog/DotSquareGen.sv
verilog/PixelFifo.sv
verilog/VideoTxBlock.sv
sim/VideoTxChecker.sv
sim/VideoTxTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the video transmit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module VideoTxTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VVideoTxTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0
